//--- compile.f
rtl/aluPkg.sv
rtl/flagPkg.sv
rtl/aluOperate.sv
rtl/aluFlag.sv
rtl/flagWord.sv
rtl/aluCore.sv
sim/aluCheck.sv
sim/aluCoreTb.sv

//--- Bender.yml
package:
  name: aluCore

sources:
  - rtl/aluPkg.sv
  - rtl/flagPkg.sv
  - rtl/aluOperate.sv
  - rtl/aluFlag.sv
  - rtl/flagWord.sv
  - rtl/aluCore.sv
  - target: simulation
    files:
      - sim/aluCheck.sv
      - sim/aluCoreTb.sv

//--- sim/aluCoreTb.sv
// Testbench top for the ALU core: clock, reset, LFSR stimulus, watchdog and the checker
`timescale 1ns/10ps
`default_nettype none

module aluCoreTb;
    import aluPkg::*;
    import flagPkg::*;

    localparam int NumCmds    = 2000;
    localparam int ClkPeriod  = 40;
    localparam int BurstStart = 1000;
    localparam int BurstLen   = 64;
    // Two periods per command, plus room for reset and drain
    localparam int WatchdogNs = NumCmds * ClkPeriod * 2 + 50 * ClkPeriod;

    logic        clk;
    logic        rstN;
    logic        cmdValid;
    aluCmdT      cmd;
    logic        resultValid;
    logic [15:0] result;
    logic        flagsValid;
    flagsT       flags;
    int          errorCount;
    int          issueCount;
    int          completeCount;
    int          resultCount;
    int          pendingCount;
    logic [15:0] lfsrState;
    int          issued;
    int          failures;

    always #(ClkPeriod / 2) clk = ~clk;

    aluCore dut (
        .clk         (clk),
        .rstN        (rstN),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .resultValid (resultValid),
        .result      (result),
        .flagsValid  (flagsValid),
        .flags       (flags)
    );

    aluCheck monitor (
        .clk           (clk),
        .rstN          (rstN),
        .cmdValid      (cmdValid),
        .cmd           (cmd),
        .resultValid   (resultValid),
        .result        (result),
        .flagsValid    (flagsValid),
        .flags         (flags),
        .errorCount    (errorCount),
        .issueCount    (issueCount),
        .completeCount (completeCount),
        .resultCount   (resultCount),
        .pendingCount  (pendingCount)
    );

    // Galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic drawBits(input int n, output logic [15:0] v);
        int i;
        v = 16'h0000;
        for (i = 0; i < n; i++) begin
            v = {v[14:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic randomCommand(output aluCmdT c);
        logic [15:0] bits;
        drawBits(4, bits);
        c.op = aluOpE'(bits[3:0] % 9);
        drawBits(1, bits);
        c.byteMode = bits[0];
        drawBits(16, bits);
        c.a = bits;
        drawBits(16, bits);
        c.b = bits;
        // Equal operands now and then, for ef and zero results
        drawBits(3, bits);
        if (bits[2:0] == 3'd0) begin
            c.b = c.a;
        end
    endtask

    initial begin
        logic [15:0] bits;
        logic        burst;
        clk       = 1'b0;
        rstN      = 1'b0;
        cmdValid  = 1'b0;
        cmd       = '0;
        lfsrState = 16'd99;
        issued    = 0;
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
        while (issued < NumCmds) begin
            @(posedge clk);
            #2;
            // One stretch of back-to-back commands
            burst = (issued >= BurstStart) && (issued < BurstStart + BurstLen);
            drawBits(2, bits);
            randomCommand(cmd);
            cmdValid = burst || (bits[1:0] != 2'b00);
            if (cmdValid) begin
                issued++;
            end
        end
        @(posedge clk);
        #2;
        cmdValid = 1'b0;
        wait (pendingCount == 0);
        // Idle cycles so a stray valid is still caught
        repeat (4) @(posedge clk);
        failures = errorCount;
        if (issueCount != issued || completeCount != issued) begin
            $display("Checker saw %0d commands and %0d completions, but %0d were driven",
                     issueCount, completeCount, issued);
            failures++;
        end
        $display("Issued %0d, completed %0d, results checked %0d, errors %0d",
                 issued, completeCount, resultCount, failures);
        if (failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WatchdogNs);
        $display("Timeout: run still busy after %0d ns, %0d of %0d commands completed",
                 WatchdogNs, completeCount, NumCmds);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/aluCheck.sv
// Checker for the ALU core: models results and flags, compares DUT outputs and counts errors
`timescale 1ns/10ps
`default_nettype none

module aluCheck (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire                 cmdValid,
    input  wire aluPkg::aluCmdT cmd,
    input  wire                 resultValid,
    input  wire [15:0]          result,
    input  wire                 flagsValid,
    input  wire flagPkg::flagsT flags,
    output int                  errorCount,
    output int                  issueCount,
    output int                  completeCount,
    output int                  resultCount,
    output int                  pendingCount
);
    import aluPkg::*;
    import flagPkg::*;

    aluCmdT      cmdQ[$];
    int          dueQ[$];
    int          cycle = 0;
    int          errs = 0;
    int          issues = 0;
    int          completes = 0;
    int          results = 0;
    flagsT       modelFlags = '0;
    logic [15:0] modelResult = 16'h0000;

    assign errorCount    = errs;
    assign issueCount    = issues;
    assign completeCount = completes;
    assign resultCount   = results;
    assign pendingCount  = issues - completes;

    task automatic reportMismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
        errs++;
        $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
    endtask

    // Reference behavior of one command against the flags before it
    task automatic modelExecute(input aluCmdT c, input flagsT old, output logic [15:0] res,
                                output logic wr, output flagsT nf);
        logic [16:0] wide;
        logic [8:0]  low;
        logic [4:0]  nib;
        logic [7:0]  daaByte;
        logic        inc;
        logic        lowAdj;
        logic        highAdj;
        nf  = old;
        wr  = (c.op != CMP);
        res = 16'h0000;
        case (c.op)
            ADD, ADC: begin
                inc  = (c.op == ADC) ? old.cf : 1'b0;
                wide = {1'b0, c.a} + {1'b0, c.b} + inc;
                low  = {1'b0, c.a[7:0]} + {1'b0, c.b[7:0]} + inc;
                nib  = {1'b0, c.a[3:0]} + {1'b0, c.b[3:0]} + inc;
                res  = wide[15:0];
                nf.cf = c.byteMode ? low[8] : wide[16];
                nf.af = nib[4];
                nf.of = c.byteMode ? (c.a[7] == c.b[7]) && (res[7] != c.a[7])
                                   : (c.a[15] == c.b[15]) && (res[15] != c.a[15]);
            end
            SUB, SBB, CMP: begin
                // Negative difference wraps and sets the top bit, which is the borrow
                inc  = (c.op == SBB) ? old.cf : 1'b0;
                wide = {1'b0, c.a} - {1'b0, c.b} - inc;
                low  = {1'b0, c.a[7:0]} - {1'b0, c.b[7:0]} - inc;
                nib  = {1'b0, c.a[3:0]} - {1'b0, c.b[3:0]} - inc;
                res  = wide[15:0];
                nf.cf = c.byteMode ? low[8] : wide[16];
                nf.af = nib[4];
                nf.of = c.byteMode ? (c.a[7] != c.b[7]) && (res[7] != c.a[7])
                                   : (c.a[15] != c.b[15]) && (res[15] != c.a[15]);
            end
            AND, OR, XOR: begin
                if (c.op == AND) begin
                    res = c.a & c.b;
                end else if (c.op == OR) begin
                    res = c.a | c.b;
                end else begin
                    res = c.a ^ c.b;
                end
                nf.cf = 1'b0;
                nf.af = 1'b0;
                nf.of = 1'b0;
            end
            default: begin
                lowAdj  = (c.a[3:0] > 4'd9) || old.af;
                highAdj = (c.a[7:0] > 8'h99) || old.cf;
                daaByte = c.a[7:0] + (lowAdj ? 8'h06 : 8'h00) + (highAdj ? 8'h60 : 8'h00);
                res     = {8'h00, daaByte};
                nf.cf   = highAdj;
                nf.af   = lowAdj;
            end
        endcase
        nf.pf = ~^res[7:0];
        if (c.op == DAA) begin
            // of and ef carry over
            nf.zf = (res[7:0] == 8'h00);
            nf.sf = res[7];
        end else begin
            nf.zf = c.byteMode ? (res[7:0] == 8'h00) : (res == 16'h0000);
            nf.sf = c.byteMode ? res[7] : res[15];
            nf.ef = c.byteMode ? (c.a[7:0] == c.b[7:0]) : (c.a == c.b);
        end
    endtask

    // Sampled mid-cycle, away from the driving and clocking edges
    always @(negedge clk) begin : compareStage
        aluCmdT      doneCmd;
        logic        due;
        logic [15:0] expResult;
        logic        expWrite;
        flagsT       expFlags;
        if (!rstN) begin
            cmdQ.delete();
            dueQ.delete();
            modelFlags  = '0;
            modelResult = 16'h0000;
        end else begin
            cycle++;
            expWrite = 1'b0;
            due = (dueQ.size() > 0) && (dueQ[0] == cycle);
            if (due) begin
                doneCmd = cmdQ.pop_front();
                void'(dueQ.pop_front());
                modelExecute(doneCmd, modelFlags, expResult, expWrite, expFlags);
                modelFlags = expFlags;
                if (expWrite) begin
                    modelResult = expResult;
                    results++;
                end
                completes++;
            end
            if (flagsValid !== due) begin
                reportMismatch("flagsValid", flagsValid, due);
            end
            if (resultValid !== (due && expWrite)) begin
                reportMismatch("resultValid", resultValid, due && expWrite);
            end
            if (flags !== modelFlags) begin
                reportMismatch("flags", flags, modelFlags);
            end
            if (result !== modelResult) begin
                reportMismatch("result", result, modelResult);
            end
            if (cmdValid === 1'b1) begin
                cmdQ.push_back(cmd);
                dueQ.push_back(cycle + 2);
                issues++;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/aluCore.sv
// Top of the ALU execution pipeline: issue register, execute stage, flag and result registers
`timescale 1ns/10ps
`default_nettype none

module aluCore (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire                 cmdValid,
    input  wire aluPkg::aluCmdT cmd,
    output logic                resultValid,
    output logic [15:0]         result,
    output logic                flagsValid,
    output flagPkg::flagsT      flags
);
    import aluPkg::*;
    import flagPkg::*;

    aluCmdT  issueCmd;
    logic    issueValid;
    aluOutT  opOut;
    opCarryT opCarries;
    flagsT   newFlags;

    // Issue stage
    always_ff @(posedge clk) begin
        if (!rstN) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= cmdValid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmdValid) begin
            issueCmd <= cmd;
        end
    end

    // Execute stage, carry and half carry come straight from the flag register
    aluOperate uOperate (
        .cmd        (issueCmd),
        .carryIn    (flags.cf),
        .auxCarryIn (flags.af),
        .out        (opOut),
        .carries    (opCarries)
    );

    aluFlag uFlag (
        .cmd      (issueCmd),
        .result   (opOut.result),
        .carries  (opCarries),
        .oldFlags (flags),
        .newFlags (newFlags)
    );

    flagWord uFlagWord (
        .clk      (clk),
        .rstN     (rstN),
        .write    (issueValid),
        .op       (issueCmd.op),
        .newFlags (newFlags),
        .flags    (flags)
    );

    // Output register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            flagsValid  <= 1'b0;
            result      <= 16'h0000;
        end else begin
            resultValid <= issueValid && opOut.write;
            flagsValid  <= issueValid;
            if (issueValid && opOut.write) begin
                result <= opOut.result;
            end
        end
    end

    resultWithFlags: assert property (
        @(posedge clk) disable iff (!rstN)
        resultValid |-> flagsValid
    ) else $error("aluCore: result without flag update");

endmodule

`default_nettype wire

//--- rtl/flagWord.sv
// Architectural flag register, written field by field under the operation's mask
`timescale 1ns/10ps
`default_nettype none

module flagWord (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire                 write,
    input  wire aluPkg::aluOpE  op,
    input  wire flagPkg::flagsT newFlags,
    output flagPkg::flagsT      flags
);
    import aluPkg::*;
    import flagPkg::*;

    flagsT mask;

    assign mask = flagMaskFor(op);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags <= '0;
        end else if (write) begin
            // Unselected fields keep their value
            flags <= (flags & ~mask) | (newFlags & mask);
        end
    end

    // DAA keeps overflow from the previous command
    daaKeepsOf: assert property (
        @(posedge clk) disable iff (!rstN)
        (write && op == DAA) |=> $stable(flags.of)
    ) else $error("flagWord: DAA changed of");

    resetClears: assert property (
        @(posedge clk)
        !rstN |=> (flags == '0)
    ) else $error("flagWord: flags not cleared after reset");

endmodule

`default_nettype wire

//--- rtl/aluFlag.sv
// Status flag generation from operands, result and adder carries; instantiated in the execute stage
`timescale 1ns/10ps
`default_nettype none

module aluFlag (
    input  wire aluPkg::aluCmdT  cmd,
    input  wire [15:0]           result,
    input  wire aluPkg::opCarryT carries,
    input  wire flagPkg::flagsT  oldFlags,
    output flagPkg::flagsT       newFlags
);
    import aluPkg::*;
    import flagPkg::*;

    logic subOp;
    logic eqLow;
    logic eqWord;
    logic zeroLow;
    logic zeroWord;
    logic ovLow;
    logic ovWord;
    logic evenParity;
    logic auxCarry;
    logic arithCarry;
    logic daaCarry;
    logic daaAux;

    assign subOp = isSubOp(cmd.op);

    // Operand equality, low byte then full word
    assign eqLow  = (cmd.a[7:0] == cmd.b[7:0]);
    assign eqWord = eqLow && (cmd.a[15:8] == cmd.b[15:8]);

    // Result zero
    assign zeroLow  = (result[7:0] == 8'h00);
    assign zeroWord = zeroLow && (result[15:8] == 8'h00);

    // Same operand signs but a different result sign
    assign ovLow  = (cmd.a[7] == carries.bEff7) && (result[7] != cmd.a[7]);
    assign ovWord = (cmd.a[15] == carries.bEff15) && (result[15] != cmd.a[15]);

    assign evenParity = ~^result[7:0];

    // cy4 is the xor of bit 4 of a, bEff and result; flip to borrow on subtract
    assign auxCarry = carries.cy4 ^ subOp;

    assign arithCarry = (cmd.byteMode ? carries.cy8 : carries.cy16) ^ subOp;

    // Decimal adjust carries
    assign daaAux   = (cmd.a[3:0] > 4'd9) || oldFlags.af;
    assign daaCarry = (cmd.a[7:0] > 8'h99) || oldFlags.cf;

    always_comb begin
        newFlags.cf = arithCarry;
        newFlags.pf = evenParity;
        newFlags.af = auxCarry;
        newFlags.zf = cmd.byteMode ? zeroLow : zeroWord;
        newFlags.sf = cmd.byteMode ? result[7] : result[15];
        newFlags.of = cmd.byteMode ? ovLow : ovWord;
        newFlags.ef = cmd.byteMode ? eqLow : eqWord;
        if (isLogicOp(cmd.op)) begin
            newFlags.cf = 1'b0;
            newFlags.of = 1'b0;
            newFlags.af = 1'b0;
        end else if (cmd.op == DAA) begin
            // DAA is always a byte operation
            newFlags.cf = daaCarry;
            newFlags.af = daaAux;
            newFlags.zf = zeroLow;
            newFlags.sf = result[7];
        end
    end

    // Logic ops never report carry, overflow or half carry
    always_comb begin
        if (isLogicOp(cmd.op)) begin
            assert final ({newFlags.cf, newFlags.of, newFlags.af} == 3'b000)
                else $error("aluFlag: carry flags set for logic op %s", cmd.op.name());
        end
    end

endmodule

`default_nettype wire

//--- rtl/aluOperate.sv
// ALU result datapath: adder, logic unit and DAA correction, exposing carries for flag logic
`timescale 1ns/10ps
`default_nettype none

module aluOperate (
    input  wire aluPkg::aluCmdT  cmd,
    input  wire                  carryIn,
    input  wire                  auxCarryIn,
    output aluPkg::aluOutT       out,
    output aluPkg::opCarryT      carries
);
    import aluPkg::*;

    logic        subOp;
    logic        logicOp;
    logic [15:0] opA;
    logic [15:0] opB;
    logic        cin;
    logic [16:0] sum;
    logic [7:0]  daaAdj;
    logic [15:0] logicRes;

    assign subOp   = isSubOp(cmd.op);
    assign logicOp = isLogicOp(cmd.op);

    // Decimal correction for the low byte of a
    always_comb begin
        daaAdj = 8'h00;
        if (cmd.a[3:0] > 4'd9 || auxCarryIn) begin
            daaAdj[3:0] = 4'h6;
        end
        if (cmd.a[7:0] > 8'h99 || carryIn) begin
            daaAdj[7:4] = 4'h6;
        end
    end

    // Operand processing, b is inverted for subtraction
    always_comb begin
        opA = cmd.a;
        opB = subOp ? ~cmd.b : cmd.b;
        cin = 1'b0;
        case (cmd.op)
            ADC: cin = carryIn;
            SUB, CMP: cin = 1'b1;
            SBB: cin = ~carryIn;
            DAA: begin
                opA = {8'h00, cmd.a[7:0]};
                opB = {8'h00, daaAdj};
            end
            default: cin = 1'b0;
        endcase
    end

    assign sum = {1'b0, opA} + {1'b0, opB} + {16'h0000, cin};

    // Carry into a bit is recovered from the sum and both operand bits
    assign carries.cy4    = opA[4] ^ opB[4] ^ sum[4];
    assign carries.cy8    = opA[8] ^ opB[8] ^ sum[8];
    assign carries.cy16   = sum[16];
    assign carries.bEff7  = opB[7];
    assign carries.bEff15 = opB[15];

    always_comb begin
        case (cmd.op)
            AND:     logicRes = cmd.a & cmd.b;
            OR:      logicRes = cmd.a | cmd.b;
            default: logicRes = cmd.a ^ cmd.b;
        endcase
    end

    // Byte mode still produces the full word; only flags narrow to bit 7
    always_comb begin
        if (logicOp) begin
            out.result = logicRes;
        end else if (cmd.op == DAA) begin
            out.result = {8'h00, sum[7:0]};
        end else begin
            out.result = sum[15:0];
        end
        // Compare only updates flags
        out.write = (cmd.op != CMP);
    end

endmodule

`default_nettype wire

//--- rtl/flagPkg.sv
// Status flag word and per-operation write masks; import in modules that produce or hold flags
`default_nettype none

package flagPkg;

    import aluPkg::*;

    typedef struct packed {
        logic cf;
        logic pf;
        logic af;
        logic zf;
        logic sf;
        logic of;
        logic ef;
    } flagsT;

    // A set bit means the operation writes that flag
    function automatic flagsT flagMaskFor(aluOpE op);
        flagsT mask;
        mask = '1;
        // Arithmetic, logic and compare write everything
        if (op == DAA) begin
            mask.of = 1'b0;
            mask.ef = 1'b0;
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

//--- rtl/aluPkg.sv
// ALU operation codes and datapath structs; import wherever commands or results are handled
`default_nettype none

package aluPkg;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        ADC = 4'd1,
        SUB = 4'd2,
        SBB = 4'd3,
        AND = 4'd4,
        OR  = 4'd5,
        XOR = 4'd6,
        CMP = 4'd7,
        DAA = 4'd8
    } aluOpE;

    typedef struct packed {
        aluOpE       op;
        logic        byteMode;
        logic [15:0] a;
        logic [15:0] b;
    } aluCmdT;

    // Adder carries plus sign bits of the processed second operand
    typedef struct packed {
        logic cy4;
        logic cy8;
        logic cy16;
        logic bEff7;
        logic bEff15;
    } opCarryT;

    typedef struct packed {
        logic [15:0] result;
        logic        write;
    } aluOutT;

    function automatic logic isSubOp(aluOpE op);
        return (op == SUB) || (op == SBB) || (op == CMP);
    endfunction

    function automatic logic isLogicOp(aluOpE op);
        return (op == AND) || (op == OR) || (op == XOR);
    endfunction

endpackage

`default_nettype wire
